//--- hw/mpbuffer.sv
// Message buffer top level
`include "mpbuffer_config.svh"

module mpbuffer (
   input  logic                      clk,
   input  logic                      reset,
   input  mpbuffer_pkg::bus_req_t    req,
   output mpbuffer_pkg::bus_rsp_t    rsp,
   output mpbuffer_pkg::noc_link_t   noc_out [`MPB_N],
   input  logic [`MPB_N-1:0]         noc_out_ready,
   input  mpbuffer_pkg::noc_link_t   noc_in [`MPB_N],
   output logic [`MPB_N-1:0]         noc_in_ready,
   output logic                      irq
);

   mpbuffer_pkg::mp_addr_u addr;

   // Region 0 is the info register, region n+1 is endpoint n
   logic [`MPB_N:0] sel;
   logic            out_of_range;

   // Info register response
   logic info_ack;
   logic info_err;

   mpbuffer_pkg::bus_req_t ep_req [`MPB_N];
   mpbuffer_pkg::bus_rsp_t ep_rsp [`MPB_N];
   logic [`MPB_N-1:0]      ep_irq;

   assign addr = req.addr;

   for (genvar n = 0; n <= `MPB_N; n++) begin : g_sel
      assign sel[n] = (addr.fields.region == 7'(n));
   end

   // Nothing decodes above the last endpoint
   assign out_of_range = (addr.fields.region > 7'(`MPB_N));

   // Info register only answers reads at offset 0
   assign info_ack = req.en & sel[0] & ~req.we & (addr.fields.offset == '0);
   assign info_err = req.en & sel[0] & (req.we | (addr.fields.offset != '0));

   // Ack and err ORed, data picked by region
   always_comb begin
      rsp.data = '0;
      rsp.ack  = info_ack;
      rsp.err  = info_err | (req.en & out_of_range);
      if (sel[0]) begin
         rsp.data = 32'(`MPB_N);
      end
      for (int i = 0; i < `MPB_N; i++) begin
         rsp.ack = rsp.ack | ep_rsp[i].ack;
         rsp.err = rsp.err | ep_rsp[i].err;
         if (sel[i+1]) begin
            rsp.data = ep_rsp[i].data;
         end
      end
   end

   // One interrupt line for the tile
   assign irq = |ep_irq;

   for (genvar n = 0; n < `MPB_N; n++) begin : g_ep
      // Request copy with en limited to this region
      assign ep_req[n] = '{
         addr: req.addr,
         we:   req.we,
         en:   req.en & sel[n+1],
         data: req.data
      };

      mpbuffer_endpoint u_endpoint (
         .clk           (clk),
         .reset         (reset),
         .req           (ep_req[n]),
         .rsp           (ep_rsp[n]),
         .noc_out       (noc_out[n]),
         .noc_out_ready (noc_out_ready[n]),
         .noc_in        (noc_in[n]),
         .noc_in_ready  (noc_in_ready[n]),
         .irq           (ep_irq[n])
      );
   end

endmodule

//--- hw/mpbuffer_endpoint.sv
// Message buffer endpoint
`include "mpbuffer_config.svh"

module mpbuffer_endpoint (
   input  logic                      clk,
   input  logic                      reset,
   input  mpbuffer_pkg::bus_req_t    req,
   output mpbuffer_pkg::bus_rsp_t    rsp,
   output mpbuffer_pkg::noc_link_t   noc_out,
   input  logic                      noc_out_ready,
   input  mpbuffer_pkg::noc_link_t   noc_in,
   output logic                      noc_in_ready,
   output logic                      irq
);

   mpbuffer_pkg::mp_addr_u addr;

   // Register access strobes
   logic wr_data;
   logic wr_last;
   logic rd_data;
   logic rd_status;
   logic wr_irq_en;

   // Egress FIFO
   logic                eg_push;
   logic                eg_pop;
   mpbuffer_pkg::flit_t eg_flit;
   mpbuffer_pkg::flit_t eg_head;
   logic                eg_empty;
   logic                eg_full;

   // Ingress FIFO
   logic                in_push;
   logic                in_pop;
   mpbuffer_pkg::flit_t in_head;
   logic                in_empty;
   logic                in_full;

   logic irq_en;

   assign addr = req.addr;

   // Offset decode on an en already gated by region
   assign wr_data   = req.en & req.we & (addr.fields.offset == mpbuffer_pkg::REG_DATA);
   assign wr_last   = req.en & req.we & (addr.fields.offset == mpbuffer_pkg::REG_LAST);
   assign wr_irq_en = req.en & req.we & (addr.fields.offset == mpbuffer_pkg::REG_IRQ_EN);
   assign rd_data   = req.en & ~req.we & (addr.fields.offset == mpbuffer_pkg::REG_DATA);
   assign rd_status = req.en & ~req.we & (addr.fields.offset == mpbuffer_pkg::REG_STATUS);

   // Send only when there is room
   assign eg_push = (wr_data | wr_last) & ~eg_full;
   assign eg_flit = '{last: wr_last, data: req.data};

   // Receive only when something waits
   assign in_pop = rd_data & ~in_empty;

   // Ack on any completed access, err on everything else
   always_comb begin
      rsp.ack  = eg_push | in_pop | rd_status | wr_irq_en;
      rsp.err  = req.en & ~rsp.ack;
      rsp.data = '0;
      if (rd_data) begin
         rsp.data = in_head.data;
      end else if (rd_status) begin
         // Last bit only meaningful with a valid head
         rsp.data = {29'b0, eg_full, in_head.last & ~in_empty, ~in_empty};
      end
   end

   // Outgoing link straight from the egress head
   assign noc_out = '{flit: eg_head, valid: ~eg_empty};
   assign eg_pop  = ~eg_empty & noc_out_ready;

   // Incoming link accepted while there is room
   assign noc_in_ready = ~in_full;
   assign in_push      = noc_in.valid & ~in_full;

   mpbuffer_fifo #(
      .DEPTH     (`MPB_SIZE)
   ) u_egress (
      .clk       (clk),
      .reset     (reset),
      .push      (eg_push),
      .push_flit (eg_flit),
      .pop       (eg_pop),
      .head_flit (eg_head),
      .empty     (eg_empty),
      .full      (eg_full)
   );

   mpbuffer_fifo #(
      .DEPTH     (`MPB_SIZE)
   ) u_ingress (
      .clk       (clk),
      .reset     (reset),
      .push      (in_push),
      .push_flit (noc_in.flit),
      .pop       (in_pop),
      .head_flit (in_head),
      .empty     (in_empty),
      .full      (in_full)
   );

   // Interrupt enable written from data bit 0
   always_ff @(posedge clk) begin
      if (reset) begin
         irq_en <= 1'b0;
      end else if (wr_irq_en) begin
         irq_en <= req.data[0];
      end
   end

   // Level interrupt while received data waits
   always_ff @(posedge clk) begin
      if (reset) begin
         irq <= 1'b0;
      end else begin
         irq <= irq_en & ~in_empty;
      end
   end

endmodule

//--- hw/mpbuffer_fifo.sv
// Show-ahead flit FIFO
`include "mpbuffer_config.svh"

module mpbuffer_fifo #(
   parameter int DEPTH = `MPB_SIZE
) (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 push,
   input  mpbuffer_pkg::flit_t  push_flit,
   input  logic                 pop,
   output mpbuffer_pkg::flit_t  head_flit,
   output logic                 empty,
   output logic                 full
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   // Flit storage
   mpbuffer_pkg::flit_t mem [DEPTH];

   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;

   logic do_push;
   logic do_pop;

   assign empty = (count == '0);
   assign full  = (count == CNT_W'(DEPTH));

   // Overflow and underflow requests are ignored
   assign do_push = push & ~full;
   assign do_pop  = pop & ~empty;

   // Head is visible without a pop
   assign head_flit = mem[rd_ptr];

   // Storage write
   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= push_flit;
      end
   end

   // Pointers and occupancy
   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            // Wrap at DEPTH even when not a power of two
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         // Simultaneous push and pop keeps the count
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

//--- hw/mpbuffer_pkg.sv
// Message buffer types
`include "mpbuffer_config.svh"

package mpbuffer_pkg;

   // One flit with its end of packet marker
   typedef struct packed {
      logic                       last;
      logic [`MPB_FLIT_WIDTH-1:0] data;
   } flit_t;

   // Forward half of a NoC link
   // Ready runs as a separate signal in the opposite direction
   typedef struct packed {
      flit_t flit;
      logic  valid;
   } noc_link_t;

   // Single cycle bus request
   typedef struct packed {
      logic [31:0] addr;
      logic        we;
      logic        en;
      logic [31:0] data;
   } bus_req_t;

   // Bus response valid in the cycle of en
   typedef struct packed {
      logic [31:0] data;
      logic        ack;
      logic        err;
   } bus_rsp_t;

   // Address split into region select and register offset
   typedef struct packed {
      logic [11:0] upper;
      logic [6:0]  region;
      logic [12:0] offset;
   } mp_addr_fields_t;

   // Address seen as raw word or as fields
   typedef union packed {
      logic [31:0]     raw;
      mp_addr_fields_t fields;
   } mp_addr_u;

   // Endpoint register offsets
   localparam logic [12:0] REG_DATA   = 13'h0;
   localparam logic [12:0] REG_LAST   = 13'h4;
   localparam logic [12:0] REG_STATUS = 13'h8;
   localparam logic [12:0] REG_IRQ_EN = 13'hc;

endpackage

//--- include/mpbuffer_config.svh
// Message buffer configuration
`ifndef MPBUFFER_CONFIG_SVH
`define MPBUFFER_CONFIG_SVH

// Data width of one NoC flit
// Must match the 32 bit bus data path
`define MPB_FLIT_WIDTH 32

// Depth of each egress and ingress FIFO in flits
`define MPB_SIZE 16

// Number of endpoints, one NoC link pair each
// At most 127 endpoints behind the 7 bit region field
`define MPB_N 2

`endif

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing --top-module mpbuffer_tb -f sources.f -o mpbuffer_sim
if [ $? -ne 0 ]; then
   echo "Verilator compile step failed"
   exit 1
fi

out=$(./obj_dir/mpbuffer_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qx "TESTS PASSED"; then
   exit 0
fi
exit 1

//--- sources.f
+incdir+include
hw/mpbuffer_pkg.sv
hw/mpbuffer_fifo.sv
hw/mpbuffer_endpoint.sv
hw/mpbuffer.sv
tests/mpbuffer_checker.sv
tests/mpbuffer_tb.sv

//--- tests/mpbuffer_checker.sv
// Message buffer protocol checks
`include "mpbuffer_config.svh"

module mpbuffer_checker (
   input logic                    clk,
   input logic                    reset,
   input mpbuffer_pkg::bus_rsp_t  rsp,
   input mpbuffer_pkg::noc_link_t noc_out [`MPB_N],
   input logic [`MPB_N-1:0]       noc_out_ready,
   input logic                    irq
);

   // Bus answers with ack or err, never both
   a_ack_err: assert property (@(posedge clk) disable iff (reset) !(rsp.ack && rsp.err))
      else $error("bus response has ack and err high together");

   // Interrupt starts low out of reset
   a_irq_reset: assert property (@(posedge clk) reset |=> !irq)
      else $error("irq high in the cycle after reset");

   for (genvar n = 0; n < `MPB_N; n++) begin : g_link
      // Stalled flit stays until accepted
      a_hold: assert property (@(posedge clk) disable iff (reset)
         (noc_out[n].valid && !noc_out_ready[n]) |=>
            (noc_out[n].valid && $stable(noc_out[n].flit)))
         else $error("noc_out[%0d] changed while stalled", n);
   end

endmodule

bind mpbuffer mpbuffer_checker u_checker (
   .clk           (clk),
   .reset         (reset),
   .rsp           (rsp),
   .noc_out       (noc_out),
   .noc_out_ready (noc_out_ready),
   .irq           (irq)
);

//--- tests/mpbuffer_tb.sv
// Message buffer testbench
`include "mpbuffer_config.svh"

module mpbuffer_tb;

   localparam int EP_W = (`MPB_N > 1) ? $clog2(`MPB_N) : 1;
   localparam mpbuffer_pkg::bus_req_t  IDLE    = '0;
   localparam mpbuffer_pkg::bus_rsp_t  NO_RSP  = '0;
   localparam mpbuffer_pkg::noc_link_t NO_FLIT = '0;

   // Inputs of one cycle and the outputs expected in it
   typedef struct {
      logic [EP_W-1:0]         ep;
      mpbuffer_pkg::bus_req_t  req;
      mpbuffer_pkg::noc_link_t link_in;
      logic                    ready;
      mpbuffer_pkg::bus_rsp_t  exp_rsp;
      mpbuffer_pkg::noc_link_t exp_link;
      logic                    exp_irq;
      logic                    exp_in_rdy;
   } step_t;

   logic                    clk;
   logic                    reset;
   mpbuffer_pkg::bus_req_t  req;
   mpbuffer_pkg::bus_rsp_t  rsp;
   mpbuffer_pkg::noc_link_t noc_out [`MPB_N];
   logic [`MPB_N-1:0]       noc_out_ready;
   mpbuffer_pkg::noc_link_t noc_in [`MPB_N];
   logic [`MPB_N-1:0]       noc_in_ready;
   logic                    irq;

   step_t steps [$];
   int    ep_cur;
   logic  in_rdy_exp;
   int    step_no;
   int    cycles = 0;
   int    limit = 0;

   mpbuffer UUT (
      .clk(clk), .reset(reset), .req(req), .rsp(rsp),
      .noc_out(noc_out), .noc_out_ready(noc_out_ready),
      .noc_in(noc_in), .noc_in_ready(noc_in_ready), .irq(irq)
   );

   initial clk = 1'b0;
   always #50 clk = ~clk;

   // Region in bits 19..13 above the register offset
   function automatic mpbuffer_pkg::bus_req_t bus_read(int region, logic [12:0] off);
      return '{addr: {12'h0, 7'(region), off}, we: 1'b0, en: 1'b1, data: 32'h0};
   endfunction

   function automatic mpbuffer_pkg::bus_req_t bus_write(int region, logic [12:0] off,
                                                       logic [31:0] data);
      return '{addr: {12'h0, 7'(region), off}, we: 1'b1, en: 1'b1, data: data};
   endfunction

   function automatic mpbuffer_pkg::bus_rsp_t ack_rsp(logic [31:0] data);
      return '{data: data, ack: 1'b1, err: 1'b0};
   endfunction

   function automatic mpbuffer_pkg::bus_rsp_t err_rsp();
      return '{data: 32'h0, ack: 1'b0, err: 1'b1};
   endfunction

   function automatic mpbuffer_pkg::noc_link_t link_flit(logic [31:0] data, logic last);
      return '{flit: '{last: last, data: data}, valid: 1'b1};
   endfunction

   function automatic void add_step(mpbuffer_pkg::bus_req_t r, mpbuffer_pkg::bus_rsp_t e,
                                    mpbuffer_pkg::noc_link_t li, logic rdy,
                                    mpbuffer_pkg::noc_link_t el, logic ei);
      steps.push_back('{ep: EP_W'(ep_cur), req: r, link_in: li, ready: rdy,
                        exp_rsp: e, exp_link: el, exp_irq: ei, exp_in_rdy: in_rdy_exp});
   endfunction

   function automatic void build_table();
      logic [31:0] d [$];
      // Info register, write and out of range accesses
      ep_cur = 0;
      in_rdy_exp = 1'b1;
      add_step(bus_read(0, 13'h0), ack_rsp(`MPB_N), NO_FLIT, 1'b1, NO_FLIT, 1'b0);
      add_step(bus_write(0, 13'h0, 32'h1), err_rsp(), NO_FLIT, 1'b1, NO_FLIT, 1'b0);
      add_step(bus_read(0, 13'h4), err_rsp(), NO_FLIT, 1'b1, NO_FLIT, 1'b0);
      add_step(bus_read(`MPB_N + 1, 13'h0), err_rsp(), NO_FLIT, 1'b1, NO_FLIT, 1'b0);
      for (int e = 0; e < `MPB_N; e++) begin
         ep_cur = e;
         // Three flit packet sent while the link stalls, then drained
         d.delete();
         repeat (3) d.push_back($urandom());
         add_step(bus_write(e + 1, mpbuffer_pkg::REG_DATA, d[0]), ack_rsp(0), NO_FLIT, 1'b0,
                  NO_FLIT, 1'b0);
         add_step(bus_write(e + 1, mpbuffer_pkg::REG_DATA, d[1]), ack_rsp(0), NO_FLIT, 1'b0,
                  link_flit(d[0], 1'b0), 1'b0);
         add_step(bus_write(e + 1, mpbuffer_pkg::REG_LAST, d[2]), ack_rsp(0), NO_FLIT, 1'b0,
                  link_flit(d[0], 1'b0), 1'b0);
         add_step(IDLE, NO_RSP, NO_FLIT, 1'b0, link_flit(d[0], 1'b0), 1'b0);
         for (int k = 0; k < 3; k++) begin
            add_step(IDLE, NO_RSP, NO_FLIT, 1'b1, link_flit(d[k], k == 2), 1'b0);
         end
         add_step(IDLE, NO_RSP, NO_FLIT, 1'b1, NO_FLIT, 1'b0);
         // Receive path with status bits following the head flit
         d.delete();
         repeat (3) d.push_back($urandom());
         add_step(IDLE, NO_RSP, link_flit(d[0], 1'b0), 1'b1, NO_FLIT, 1'b0);
         add_step(bus_read(e + 1, mpbuffer_pkg::REG_STATUS), ack_rsp(32'h1),
                  link_flit(d[1], 1'b0), 1'b1, NO_FLIT, 1'b0);
         add_step(bus_read(e + 1, mpbuffer_pkg::REG_DATA), ack_rsp(d[0]),
                  link_flit(d[2], 1'b1), 1'b1, NO_FLIT, 1'b0);
         add_step(bus_read(e + 1, mpbuffer_pkg::REG_DATA), ack_rsp(d[1]), NO_FLIT, 1'b1,
                  NO_FLIT, 1'b0);
         add_step(bus_read(e + 1, mpbuffer_pkg::REG_STATUS), ack_rsp(32'h3), NO_FLIT, 1'b1,
                  NO_FLIT, 1'b0);
         add_step(bus_read(e + 1, mpbuffer_pkg::REG_DATA), ack_rsp(d[2]), NO_FLIT, 1'b1,
                  NO_FLIT, 1'b0);
         add_step(bus_read(e + 1, mpbuffer_pkg::REG_STATUS), ack_rsp(32'h0), NO_FLIT, 1'b1,
                  NO_FLIT, 1'b0);
         add_step(bus_read(e + 1, mpbuffer_pkg::REG_DATA), err_rsp(), NO_FLIT, 1'b1,
                  NO_FLIT, 1'b0);
         // Interrupt lags the enable and the ingress state by one edge
         add_step(bus_write(e + 1, mpbuffer_pkg::REG_IRQ_EN, 32'h1), ack_rsp(0), NO_FLIT, 1'b1,
                  NO_FLIT, 1'b0);
         add_step(IDLE, NO_RSP, NO_FLIT, 1'b1, NO_FLIT, 1'b0);
         add_step(IDLE, NO_RSP, link_flit(d[0], 1'b1), 1'b1, NO_FLIT, 1'b0);
         add_step(IDLE, NO_RSP, NO_FLIT, 1'b1, NO_FLIT, 1'b0);
         add_step(bus_read(e + 1, mpbuffer_pkg::REG_DATA), ack_rsp(d[0]), NO_FLIT, 1'b1,
                  NO_FLIT, 1'b1);
         add_step(IDLE, NO_RSP, NO_FLIT, 1'b1, NO_FLIT, 1'b1);
         add_step(bus_write(e + 1, mpbuffer_pkg::REG_IRQ_EN, 32'h0), ack_rsp(0), NO_FLIT, 1'b1,
                  NO_FLIT, 1'b0);
         // Fill the egress FIFO against a stalled link
         d.delete();
         repeat (`MPB_SIZE) d.push_back($urandom());
         for (int k = 0; k < `MPB_SIZE; k++) begin
            add_step(bus_write(e + 1, mpbuffer_pkg::REG_DATA, d[k]), ack_rsp(0), NO_FLIT, 1'b0,
                     (k == 0) ? NO_FLIT : link_flit(d[0], 1'b0), 1'b0);
         end
         add_step(bus_write(e + 1, mpbuffer_pkg::REG_DATA, $urandom()), err_rsp(), NO_FLIT,
                  1'b0, link_flit(d[0], 1'b0), 1'b0);
         add_step(bus_read(e + 1, mpbuffer_pkg::REG_STATUS), ack_rsp(32'h4), NO_FLIT, 1'b0,
                  link_flit(d[0], 1'b0), 1'b0);
         for (int k = 0; k < `MPB_SIZE; k++) begin
            add_step(IDLE, NO_RSP, NO_FLIT, 1'b1, link_flit(d[k], 1'b0), 1'b0);
         end
         add_step(IDLE, NO_RSP, NO_FLIT, 1'b1, NO_FLIT, 1'b0);
         // Full ingress FIFO pushes back a held flit until the first pop
         d.delete();
         repeat (`MPB_SIZE + 1) d.push_back($urandom());
         for (int k = 0; k < `MPB_SIZE; k++) begin
            add_step(IDLE, NO_RSP, link_flit(d[k], 1'b0), 1'b1, NO_FLIT, 1'b0);
         end
         in_rdy_exp = 1'b0;
         add_step(IDLE, NO_RSP, link_flit(d[`MPB_SIZE], 1'b1), 1'b1, NO_FLIT, 1'b0);
         add_step(bus_read(e + 1, mpbuffer_pkg::REG_DATA), ack_rsp(d[0]),
                  link_flit(d[`MPB_SIZE], 1'b1), 1'b1, NO_FLIT, 1'b0);
         in_rdy_exp = 1'b1;
         for (int k = 1; k <= `MPB_SIZE; k++) begin
            add_step(bus_read(e + 1, mpbuffer_pkg::REG_DATA), ack_rsp(d[k]),
                     (k == 1) ? link_flit(d[`MPB_SIZE], 1'b1) : NO_FLIT, 1'b1, NO_FLIT, 1'b0);
         end
      end
   endfunction

   task automatic fail_run(string msg);
      $display("%s", msg);
      $display("TESTS FAILED");
      $fatal(1, "run stopped at the first error");
   endtask

   // Response data only matters for an acknowledged read
   task automatic check_rsp(string name, mpbuffer_pkg::bus_rsp_t got,
                            mpbuffer_pkg::bus_rsp_t exp, logic cmp_data);
      if (got.ack !== exp.ack || got.err !== exp.err || (cmp_data && got.data !== exp.data)) begin
         fail_run($sformatf("Error: %s got %h expected %h at step %0d", name, got, exp, step_no));
      end
   endtask

   // Flit contents only matter while valid
   task automatic check_link(string name, mpbuffer_pkg::noc_link_t got,
                             mpbuffer_pkg::noc_link_t exp);
      if (got.valid !== exp.valid || (exp.valid && got.flit !== exp.flit)) begin
         fail_run($sformatf("Error: %s got %h expected %h at step %0d", name, got, exp, step_no));
      end
   endtask

   task automatic check_bit(string name, logic got, logic exp);
      if (got !== exp) begin
         fail_run($sformatf("Error: %s got %h expected %h at step %0d", name, got, exp, step_no));
      end
   endtask

   // Run limit in clock cycles
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (limit > 0 && cycles >= limit) begin
         $display("Timeout: the step table did not finish within %0d cycles", limit);
         $display("TESTS FAILED");
         $fatal(1, "timeout");
      end
   end

   initial begin
      step_t s;
      void'($urandom(44461));
      reset = 1'b1;
      req = IDLE;
      noc_out_ready = '1;
      for (int n = 0; n < `MPB_N; n++) begin
         noc_in[n] = NO_FLIT;
      end
      build_table();
      limit = steps.size() * 4 + 50;
      repeat (2) @(negedge clk);
      reset = 1'b0;
      foreach (steps[i]) begin
         @(negedge clk);
         s = steps[i];
         step_no = i;
         req = s.req;
         // Links not under test stay idle and ready
         noc_out_ready = '1;
         noc_out_ready[s.ep] = s.ready;
         for (int n = 0; n < `MPB_N; n++) begin
            noc_in[n] = NO_FLIT;
         end
         noc_in[s.ep] = s.link_in;
         // Sample halfway to the rising edge
         #25;
         check_rsp("rsp", rsp, s.exp_rsp, s.req.en & ~s.req.we & s.exp_rsp.ack);
         check_link($sformatf("noc_out[%0d]", s.ep), noc_out[s.ep], s.exp_link);
         check_bit("irq", irq, s.exp_irq);
         check_bit($sformatf("noc_in_ready[%0d]", s.ep), noc_in_ready[s.ep], s.exp_in_rdy);
      end
      @(negedge clk);
      $display("TESTS PASSED");
      $finish;
   end

endmodule
